// ==== src/chip8_pkg.sv ====
// ====================
// CHIP-8 shared types
// Widths, states, instruction views, ALU and writeback records
// ====================
package chip8_pkg;

    // Basic widths
    typedef logic [11:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  reg_idx_t;

    // Instruction sequencer states
    typedef enum logic [2:0] {
        fetch,
        decode,
        execute,
        writeback,
        pc_update
    } state_t;

    // Program counter update kinds
    typedef enum logic [1:0] {
        inc,
        skip,
        jump
    } pc_op_t;

    // Address form: opcode and 12-bit target
    typedef struct packed {
        logic [3:0] op;
        addr_t      nnn;
    } instr_addr_t;

    // Register form: kk is y joined with n
    typedef struct packed {
        logic [3:0] op;
        reg_idx_t   x;
        reg_idx_t   y;
        logic [3:0] n;
    } instr_reg_t;

    // One instruction word seen two ways
    typedef union packed {
        instr_addr_t addr;
        instr_reg_t  regs;
    } instr_u;

    // ALU output, 19 bits
    typedef struct packed {
        byte_t result;
        logic  result_we;
        byte_t flag;
        logic  flag_we;
        logic  skip;
    } alu_out_t;

    // Writeback record, 21 bits
    typedef struct packed {
        reg_idx_t x;
        byte_t    value;
        logic     flag_we;
        byte_t    flag;
    } wb_t;

    // VF index
    localparam reg_idx_t flag_reg = 4'd15;
    // Bytes per instruction
    localparam addr_t pc_step = 12'd2;
    localparam int stack_depth = 16;

endpackage

// ==== src/alu.sv ====
// ====================
// CHIP-8 ALU
// Result, VF flag and skip compare in one cycle
// ====================
module alu (
    input  chip8_pkg::instr_u   instr,
    input  chip8_pkg::byte_t    vx,
    input  chip8_pkg::byte_t    vy,
    input  chip8_pkg::byte_t    delay,
    output chip8_pkg::alu_out_t res
);
    import chip8_pkg::*;

    logic [3:0] op;
    logic [3:0] n;
    byte_t      kk;
    logic [8:0] sum;

    assign op  = instr.regs.op;
    assign n   = instr.regs.n;
    assign kk  = {instr.regs.y, instr.regs.n};
    // Carry in bit 8
    assign sum = {1'b0, vx} + {1'b0, vy};

    always_comb begin
        res = '0;
        case (op)
            // Skip compares
            4'h3: res.skip = (vx == kk);
            4'h4: res.skip = (vx != kk);
            4'h5: res.skip = (n == 4'h0) && (vx == vy);
            4'h9: res.skip = (n == 4'h0) && (vx != vy);
            // Immediate load and add, VF untouched
            4'h6: begin
                res.result    = kk;
                res.result_we = 1'b1;
            end
            4'h7: begin
                res.result    = vx + kk;
                res.result_we = 1'b1;
            end
            4'h8: begin
                res.result_we = 1'b1;
                case (n)
                    4'h0: res.result = vy;
                    4'h1: res.result = vx | vy;
                    4'h2: res.result = vx & vy;
                    4'h3: res.result = vx ^ vy;
                    4'h4: begin
                        res.result  = sum[7:0];
                        res.flag    = {7'd0, sum[8]};
                        res.flag_we = 1'b1;
                    end
                    4'h5: begin
                        res.result  = vx - vy;
                        res.flag    = {7'd0, vx > vy};
                        res.flag_we = 1'b1;
                    end
                    4'h6: begin
                        res.result  = vx >> 1;
                        res.flag    = {7'd0, vx[0]};
                        res.flag_we = 1'b1;
                    end
                    4'h7: begin
                        res.result  = vy - vx;
                        res.flag    = {7'd0, vy > vx};
                        res.flag_we = 1'b1;
                    end
                    4'hE: begin
                        res.result  = vx << 1;
                        res.flag    = {7'd0, vx[7]};
                        res.flag_we = 1'b1;
                    end
                    // Unknown 8xy form writes nothing
                    default: res.result_we = 1'b0;
                endcase
            end
            // Fx07 reads the delay timer
            4'hF: begin
                if (kk == 8'h07) begin
                    res.result    = delay;
                    res.result_we = 1'b1;
                end
            end
            default: res = '0;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
// ====================
// CHIP-8 V registers
// Sixteen bytes, three reads, value then flag write
// ====================
module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  chip8_pkg::reg_idx_t  rd_x,
    input  chip8_pkg::reg_idx_t  rd_y,
    output chip8_pkg::byte_t     vx,
    output chip8_pkg::byte_t     vy,
    output chip8_pkg::byte_t     v0,
    input  logic                 we,
    input  chip8_pkg::wb_t       wb
);
    import chip8_pkg::*;

    byte_t regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb.x] <= wb.value;
            // Later write wins when x is VF
            if (wb.flag_we) begin
                regs[flag_reg] <= wb.flag;
            end
        end
    end

    // Asynchronous reads
    assign vx = regs[rd_x];
    assign vy = regs[rd_y];
    assign v0 = regs[0];

endmodule

// ==== src/pc_stack.sv ====
// ====================
// CHIP-8 PC and stack
// Program counter with sixteen-entry return stack
// ====================
module pc_stack #(
    parameter chip8_pkg::addr_t reset_pc = 12'h200
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  logic               pop,
    input  logic               upd_en,
    input  chip8_pkg::pc_op_t  pc_op,
    input  chip8_pkg::addr_t   jump_addr,
    output chip8_pkg::addr_t   pc
);
    import chip8_pkg::*;

    localparam int ptr_w = $clog2(stack_depth);

    addr_t            stack [stack_depth];
    // One extra bit so a full stack is visible
    logic [ptr_w:0]   sp;
    logic [ptr_w-1:0] top_idx;

    assign top_idx = sp[ptr_w-1:0] - 1'b1;

    // Stack memory, call pushes the address of the call
    always_ff @(posedge clk) begin
        if (push) begin
            stack[sp[ptr_w-1:0]] <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
            sp <= '0;
        end else begin
            if (push) begin
                sp <= sp + 1'b1;
            end else if (pop) begin
                // Popped address, the inc step then adds 2
                pc <= stack[top_idx];
                sp <= sp - 1'b1;
            end
            if (upd_en) begin
                case (pc_op)
                    skip:    pc <= pc + pc_step + pc_step;
                    jump:    pc <= jump_addr;
                    default: pc <= pc + pc_step;
                endcase
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (sp < (ptr_w + 1)'(stack_depth)));

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> (sp != '0));

endmodule

// ==== src/timers.sv ====
// ====================
// CHIP-8 timers
// Delay and sound countdown from a divided tick
// ====================
module timers #(
    parameter int tick_div = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_delay,
    input  logic              load_sound,
    input  chip8_pkg::byte_t  load_val,
    output chip8_pkg::byte_t  delay,
    output logic              sound_on
);
    import chip8_pkg::*;

    localparam int div_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [div_w-1:0] div_cnt;
    logic             tick;
    byte_t            sound;

    // Free-running divider, one tick every tick_div cycles
    assign tick = (div_cnt == div_w'(tick_div - 1));

    always_ff @(posedge clk) begin
        if (rst || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Load beats tick, count stops at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            delay <= '0;
            sound <= '0;
        end else begin
            if (load_delay) begin
                delay <= load_val;
            end else if (tick && delay != '0) begin
                delay <= delay - 1'b1;
            end
            if (load_sound) begin
                sound <= load_val;
            end else if (tick && sound != '0) begin
                sound <= sound - 1'b1;
            end
        end
    end

    assign sound_on = (sound != '0);

endmodule

// ==== src/cpu_control.sv ====
// ====================
// CHIP-8 sequencer
// Five-state FSM, strobes, writeback and PC-update select
// ====================
module cpu_control (
    input  logic                clk,
    input  logic                rst,
    input  chip8_pkg::instr_u   instr,
    input  chip8_pkg::alu_out_t alu_res,
    input  chip8_pkg::byte_t    v0,
    input  chip8_pkg::byte_t    vx,
    output logic                fetch_en,
    output chip8_pkg::instr_u   instr_q,
    output logic                wb_valid,
    output chip8_pkg::wb_t      wb,
    output logic                push,
    output logic                pop,
    output logic                upd_en,
    output chip8_pkg::pc_op_t   pc_op,
    output chip8_pkg::addr_t    jump_addr,
    output logic                load_delay,
    output logic                load_sound,
    output chip8_pkg::byte_t    load_val
);
    import chip8_pkg::*;

    state_t     state;
    state_t     state_next;
    logic       decode_en;
    logic       exec_en;
    logic       wb_en;
    alu_out_t   alu_q;
    logic [3:0] op;
    byte_t      kk;
    logic       is_ret;

    // Fields of the latched word
    assign op     = instr_q.regs.op;
    assign kk     = {instr_q.regs.y, instr_q.regs.n};
    assign is_ret = (instr_q == 16'h00EE);

    // Fixed walk through the five steps
    always_comb begin
        case (state)
            fetch:     state_next = decode;
            decode:    state_next = execute;
            execute:   state_next = writeback;
            writeback: state_next = pc_update;
            default:   state_next = fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch;
        end else begin
            state <= state_next;
        end
    end

    // One strobe per state
    assign fetch_en  = (state == fetch);
    assign decode_en = (state == decode);
    assign exec_en   = (state == execute);
    assign wb_en     = (state == writeback);
    assign upd_en    = (state == pc_update);

    // Instruction port answers during decode
    always_ff @(posedge clk) begin
        if (decode_en) begin
            instr_q <= instr;
        end
    end

    // Hold ALU result for writeback and skip
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_q <= '0;
        end else if (exec_en) begin
            alu_q <= alu_res;
        end
    end

    // Stack and timer strobes in execute
    assign push       = exec_en && (op == 4'h2);
    assign pop        = exec_en && is_ret;
    assign load_delay = exec_en && (op == 4'hF) && (kk == 8'h15);
    assign load_sound = exec_en && (op == 4'hF) && (kk == 8'h18);
    assign load_val   = vx;

    // Writeback record built from the held ALU result
    assign wb.x       = instr_q.regs.x;
    assign wb.value   = alu_q.result;
    assign wb.flag_we = alu_q.flag_we;
    assign wb.flag    = alu_q.flag;
    assign wb_valid   = wb_en && alu_q.result_we;

    // PC update kind
    always_comb begin
        pc_op = inc;
        case (op)
            4'h1, 4'h2, 4'hB: pc_op = jump;
            4'h3, 4'h4, 4'h5, 4'h9: begin
                if (alu_q.skip) begin
                    pc_op = skip;
                end
            end
            default: pc_op = inc;
        endcase
    end

    // Bnnn adds V0 and wraps in 12 bits
    assign jump_addr = (op == 4'hB) ? instr_q.addr.nnn + addr_t'(v0) : instr_q.addr.nnn;

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {fetch, decode, execute, writeback, pc_update});

endmodule

// ==== src/chip8_top.sv ====
// ====================
// CHIP-8 instruction engine
// Sequencer, datapath and timers behind an instruction port
// ====================
module chip8_top #(
    parameter int               tick_div = 8,
    parameter chip8_pkg::addr_t reset_pc = 12'h200
) (
    input  logic               clk,
    input  logic               rst,
    output logic               fetch_en,
    output chip8_pkg::addr_t   fetch_addr,
    input  chip8_pkg::instr_u  instr,
    output logic               wb_valid,
    output chip8_pkg::wb_t     wb,
    output logic               sound_on
);
    import chip8_pkg::*;

    // Decoded instruction and register reads
    instr_u   instr_q;
    byte_t    vx;
    byte_t    vy;
    byte_t    v0;
    byte_t    delay;
    alu_out_t alu_res;

    // PC and stack control
    logic   push;
    logic   pop;
    logic   upd_en;
    pc_op_t pc_op;
    addr_t  jump_addr;

    // Timer loads
    logic  load_delay;
    logic  load_sound;
    byte_t load_val;

    cpu_control u_control (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .alu_res    (alu_res),
        .v0         (v0),
        .vx         (vx),
        .fetch_en   (fetch_en),
        .instr_q    (instr_q),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .push       (push),
        .pop        (pop),
        .upd_en     (upd_en),
        .pc_op      (pc_op),
        .jump_addr  (jump_addr),
        .load_delay (load_delay),
        .load_sound (load_sound),
        .load_val   (load_val)
    );

    alu u_alu (
        .instr (instr_q),
        .vx    (vx),
        .vy    (vy),
        .delay (delay),
        .res   (alu_res)
    );

    // Register file reads follow the latched instruction
    reg_file u_regs (
        .clk  (clk),
        .rst  (rst),
        .rd_x (instr_q.regs.x),
        .rd_y (instr_q.regs.y),
        .vx   (vx),
        .vy   (vy),
        .v0   (v0),
        .we   (wb_valid),
        .wb   (wb)
    );

    // The PC is the fetch address
    pc_stack #(.reset_pc(reset_pc)) u_pc (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .pop       (pop),
        .upd_en    (upd_en),
        .pc_op     (pc_op),
        .jump_addr (jump_addr),
        .pc        (fetch_addr)
    );

    timers #(.tick_div(tick_div)) u_timers (
        .clk        (clk),
        .rst        (rst),
        .load_delay (load_delay),
        .load_sound (load_sound),
        .load_val   (load_val),
        .delay      (delay),
        .sound_on   (sound_on)
    );

endmodule

// ==== test/tb_clock.sv ====
// ====================
// Testbench clock and reset
// 10 ns clock, reset held for a few cycles
// ====================
module tb_clock #(
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== test/tb_chip8.sv ====
// ====================
// CHIP-8 engine testbench
// Instruction table serves as program memory and expected trace
// ====================
module tb_chip8;
    timeunit 1ns;
    timeprecision 1ps;
    import chip8_pkg::*;

    localparam int tick_div = 8;

    // What each step is checked for
    localparam logic [1:0] k_none  = 2'd0;
    localparam logic [1:0] k_wb    = 2'd1;
    localparam logic [1:0] k_delay = 2'd2;
    localparam logic [1:0] k_sound = 2'd3;

    // One executed instruction with its expected outcome
    typedef struct packed {
        addr_t      addr;
        instr_u     ins;
        logic [1:0] kind;
        wb_t        exp;
    } step_t;

    logic   clk;
    logic   rst;
    logic   fetch_en;
    addr_t  fetch_addr;
    instr_u instr;
    logic   wb_valid;
    wb_t    wb;
    logic   sound_on;

    instr_u mem [0:4095];
    step_t  steps [$];
    // Reference copy of the V registers
    byte_t  vm [16];
    addr_t  ret_stack [$];
    // Address of the next instruction while the table is built
    addr_t  cur;
    int     seed = 67;
    int     n_checks = 0;
    int     n_errors = 0;
    logic   built = 1'b0;
    byte_t  sound_val;

    tb_clock #(.reset_cycles(4)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    chip8_top #(
        .tick_div (tick_div),
        .reset_pc (12'h200)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .sound_on   (sound_on)
    );

    // Program memory answers in the decode cycle
    always @(posedge clk) begin
        if (fetch_en) begin
            instr <= mem[fetch_addr];
        end
    end

    function automatic byte_t rand_byte();
        rand_byte = byte_t'($random(seed));
    endfunction

    function automatic instr_u make_instr(input logic [3:0] op, input reg_idx_t x,
                                          input reg_idx_t y, input logic [3:0] n);
        make_instr = {op, x, y, n};
    endfunction

    function automatic wb_t make_wb(input reg_idx_t x, input byte_t value,
                                    input logic flag_we, input byte_t flag);
        make_wb.x       = x;
        make_wb.value   = value;
        make_wb.flag_we = flag_we;
        make_wb.flag    = flag;
    endfunction

    // Arithmetic rules of the 8xyn group
    task automatic ref_alu(input logic [3:0] n, input byte_t a, input byte_t b,
                           output byte_t val, output logic fwe, output byte_t flag);
        int wide;
        val  = 8'h00;
        fwe  = 1'b0;
        flag = 8'h00;
        case (n)
            4'h0: val = b;
            4'h1: val = a | b;
            4'h2: val = a & b;
            4'h3: val = a ^ b;
            4'h4: begin
                wide = int'(a) + int'(b);
                val  = byte_t'(wide % 256);
                fwe  = 1'b1;
                flag = (wide > 255) ? 8'd1 : 8'd0;
            end
            4'h5: begin
                val  = a - b;
                fwe  = 1'b1;
                flag = (a > b) ? 8'd1 : 8'd0;
            end
            4'h6: begin
                val  = a / 2;
                fwe  = 1'b1;
                flag = byte_t'(a % 2);
            end
            4'h7: begin
                val  = b - a;
                fwe  = 1'b1;
                flag = (b > a) ? 8'd1 : 8'd0;
            end
            4'hE: begin
                val  = {a[6:0], 1'b0};
                fwe  = 1'b1;
                flag = a[7] ? 8'd1 : 8'd0;
            end
            default: val = 8'h00;
        endcase
    endtask

    // Store one instruction at the current address and record its step
    task automatic emit(input instr_u ins, input logic [1:0] kind, input wb_t exp,
                        input addr_t next);
        step_t st;
        st.addr = cur;
        st.ins  = ins;
        st.kind = kind;
        st.exp  = exp;
        mem[cur] = ins;
        steps.push_back(st);
        cur = next;
    endtask

    task automatic load_imm(input reg_idx_t x, input byte_t kk);
        emit(make_instr(4'h6, x, kk[7:4], kk[3:0]), k_wb, make_wb(x, kk, 1'b0, 8'h00),
             cur + pc_step);
        vm[x] = kk;
    endtask

    // 7xkk wraps and leaves VF alone
    task automatic add_imm(input reg_idx_t x, input byte_t kk);
        byte_t sum;
        sum = vm[x] + kk;
        emit(make_instr(4'h7, x, kk[7:4], kk[3:0]), k_wb, make_wb(x, sum, 1'b0, 8'h00),
             cur + pc_step);
        vm[x] = sum;
    endtask

    task automatic arith(input reg_idx_t x, input reg_idx_t y, input logic [3:0] n);
        byte_t val;
        logic  fwe;
        byte_t flag;
        ref_alu(n, vm[x], vm[y], val, fwe, flag);
        emit(make_instr(4'h8, x, y, n), k_wb, make_wb(x, val, fwe, flag), cur + pc_step);
        vm[x] = val;
        // VF ends up with the flag even when x is 15
        if (fwe) begin
            vm[flag_reg] = flag;
        end
    endtask

    // 3xkk and 4xkk
    task automatic skip_kk(input logic [3:0] op, input reg_idx_t x, input byte_t kk);
        logic taken;
        taken = (op == 4'h3) ? (vm[x] == kk) : (vm[x] != kk);
        emit(make_instr(op, x, kk[7:4], kk[3:0]), k_none, make_wb(0, 0, 1'b0, 0),
             taken ? cur + 12'd4 : cur + pc_step);
    endtask

    // 5xy0 and 9xy0
    task automatic skip_xy(input logic [3:0] op, input reg_idx_t x, input reg_idx_t y);
        logic taken;
        taken = (op == 4'h5) ? (vm[x] == vm[y]) : (vm[x] != vm[y]);
        emit(make_instr(op, x, y, 4'h0), k_none, make_wb(0, 0, 1'b0, 0),
             taken ? cur + 12'd4 : cur + pc_step);
    endtask

    // 1nnn or Bnnn
    task automatic jump_to(input logic [3:0] op, input addr_t nnn);
        instr_u ins;
        addr_t  target;
        ins    = {op, nnn};
        target = (op == 4'hB) ? nnn + addr_t'(vm[0]) : nnn;
        emit(ins, k_none, make_wb(0, 0, 1'b0, 0), target);
    endtask

    task automatic call_sub(input addr_t nnn);
        instr_u ins;
        ins = {4'h2, nnn};
        ret_stack.push_back(cur);
        emit(ins, k_none, make_wb(0, 0, 1'b0, 0), nnn);
    endtask

    // Resumes after the matching call
    task automatic return_sub();
        instr_u ins;
        addr_t  back;
        ins  = 16'h00EE;
        back = ret_stack.pop_back();
        emit(ins, k_none, make_wb(0, 0, 1'b0, 0), back + pc_step);
    endtask

    task automatic build_program();
        // Unused words hold keypad opcodes that act as a plain increment
        for (int a = 0; a < 4096; a++) begin
            mem[a] = {4'hE, 12'(a)};
        end
        for (int r = 0; r < 16; r++) begin
            vm[r] = 8'h00;
        end
        cur = 12'h200;
        // Loads and adds where one add wraps past 255
        load_imm(4'd1, rand_byte());
        load_imm(4'd2, rand_byte());
        add_imm(4'd1, rand_byte());
        load_imm(4'd15, 8'hF0);
        add_imm(4'd15, 8'h20);
        // Every 8xyn form on random operands
        for (int n = 0; n < 16; n++) begin
            if (n <= 7 || n == 14) begin
                load_imm(4'd3, rand_byte());
                load_imm(4'd4, rand_byte());
                arith(4'd3, 4'd4, 4'(n));
            end
        end
        // Equal operands give no borrow flag
        load_imm(4'd3, 8'h21);
        load_imm(4'd4, 8'h21);
        arith(4'd3, 4'd4, 4'h5);
        // x is VF and VF is then copied out to show which write won
        for (int n = 4; n < 16; n++) begin
            if (n <= 7 || n == 14) begin
                load_imm(4'd15, rand_byte());
                load_imm(4'd5, rand_byte());
                arith(4'd15, 4'd5, 4'(n));
                arith(4'd6, 4'd15, 4'h0);
            end
        end
        // Skips both taken and not taken
        load_imm(4'd7, 8'h5A);
        load_imm(4'd8, 8'h5A);
        load_imm(4'd9, 8'h11);
        skip_kk(4'h3, 4'd7, 8'h5A);
        skip_kk(4'h3, 4'd7, 8'h5B);
        skip_kk(4'h4, 4'd7, 8'h5B);
        skip_kk(4'h4, 4'd7, 8'h5A);
        skip_xy(4'h5, 4'd7, 4'd8);
        skip_xy(4'h5, 4'd7, 4'd9);
        skip_xy(4'h9, 4'd7, 4'd9);
        skip_xy(4'h9, 4'd7, 4'd8);
        // Jumps
        jump_to(4'h1, 12'h300);
        load_imm(4'd0, 8'h10);
        jump_to(4'hB, 12'h340);
        // Calls two deep
        call_sub(12'h400);
        load_imm(4'd10, rand_byte());
        call_sub(12'h480);
        load_imm(4'd11, rand_byte());
        return_sub();
        return_sub();
        // Delay load then read back
        load_imm(4'd12, 8'h40);
        emit(make_instr(4'hF, 4'd12, 4'h1, 4'h5), k_none, make_wb(0, 0, 1'b0, 0),
             cur + pc_step);
        emit(make_instr(4'hF, 4'd13, 4'h0, 4'h7), k_delay, make_wb(4'd13, vm[12], 1'b0, 0),
             cur + pc_step);
        // Short sound
        sound_val = 8'd3;
        load_imm(4'd14, sound_val);
        emit(make_instr(4'hF, 4'd14, 4'h1, 4'h8), k_sound, make_wb(0, 0, 1'b0, 0),
             cur + pc_step);
    endtask

    task automatic check_wb(input wb_t actual, input wb_t expected);
        n_checks++;
        // Flag byte only matters when it is written
        if (actual.x !== expected.x || actual.value !== expected.value ||
            actual.flag_we !== expected.flag_we ||
            (expected.flag_we && actual.flag !== expected.flag)) begin
            n_errors++;
            $display("** Error at %0t ns: wb x=%h value=%h flag_we=%b flag=%h", $time,
                     actual.x, actual.value, actual.flag_we, actual.flag);
            $display("   expected x=%h value=%h flag_we=%b flag=%h",
                     expected.x, expected.value, expected.flag_we, expected.flag);
        end
    endtask

    task automatic check_addr(input addr_t actual, input addr_t expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("** Error at %0t ns: fetch_addr %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_level(input logic actual, input logic expected, input string what);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Lands on the first negative edge after reset is released
    task automatic wait_reset_release();
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
    endtask

    // Stop if the engine stalls
    initial begin
        wait (built);
        #((steps.size() * 5 + 200) * 10);
        $display("Timeout: the instruction table did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        wb_t exp;
        int  errs_before;
        int  cycles;
        instr = '0;
        build_program();
        built = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            errs_before = n_errors;
            if (i == 0) begin
                wait_reset_release();
            end else begin
                // Next fetch comes five cycles after the last one
                repeat (2) @(negedge clk);
            end
            check_level(fetch_en, 1'b1, "fetch_en");
            check_addr(fetch_addr, steps[i].addr);
            // Writeback cycle three after fetch
            repeat (3) @(negedge clk);
            check_level(fetch_en, 1'b0, "fetch_en in writeback");
            exp = steps[i].exp;
            case (steps[i].kind)
                k_wb: begin
                    check_level(wb_valid, 1'b1, "wb_valid");
                    check_wb(wb, exp);
                end
                k_delay: begin
                    // One tick may fall between load and read
                    if (wb.value == exp.value - 8'd1) begin
                        exp.value = exp.value - 8'd1;
                    end
                    check_level(wb_valid, 1'b1, "wb_valid");
                    check_wb(wb, exp);
                end
                k_sound: begin
                    check_level(wb_valid, 1'b0, "wb_valid");
                    check_level(sound_on, 1'b1, "sound_on after load");
                end
                default: check_level(wb_valid, 1'b0, "wb_valid");
            endcase
            $display("step %0d pc=%h instr=%h %s", i, steps[i].addr, steps[i].ins,
                     (n_errors == errs_before) ? "ok" : "mismatch");
        end
        // Sound must end within (value + 1) ticks
        cycles = 0;
        while (sound_on && cycles < (int'(sound_val) + 1) * tick_div) begin
            @(negedge clk);
            cycles++;
        end
        check_level(sound_on, 1'b0, "sound_on after countdown");
        $display("sound_on low after %0d cycles", cycles);
        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/chip8_pkg.sv
src/alu.sv
src/reg_file.sv
src/pc_stack.sv
src/timers.sv
src/cpu_control.sv
src/chip8_top.sv
test/tb_clock.sv
test/tb_chip8.sv
